/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module bit_align_tb \
		-f project.f --Mdir obj_dir -o bit_align_sim
	./obj_dir/bit_align_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/bit_align_pkg.sv */
package bit_align_pkg;

   // --------------------
   // Tap indexing

   localparam int tap_width = 8;                     // 256-tap IOD delay line
   localparam int tap_count = 2 ** tap_width;

   typedef logic [tap_width-1:0] tap_t;
   typedef logic [tap_width:0]   width_t;            // Eye width up to tap_count

   localparam tap_t tap_last = tap_t'(tap_count - 1);

   // --------------------
   // IOD interface

   // Pulses and direction towards the delay line
   typedef struct packed {
      logic clr_flags;                               // Clear sticky early/late flags
      logic load;                                    // Reload delay to tap 0
      logic dir;                                     // High moves to higher taps
      logic move;                                    // Step one tap
   } iod_ctrl_t;

   // Flags back from the IOD sampler
   typedef struct packed {
      logic early;
      logic late;
      logic oor;                                     // Delay out of range
   } iod_flags_t;

   // --------------------
   // Control and status

   typedef struct packed {
      logic restart;
      logic hold;                                    // Freeze new tap steps
      logic skip;                                    // Sampled at start of run
   } align_cmd_t;

   typedef struct packed {
      logic start;
      logic done;
      logic err;                                     // Eye below minimum width
      logic oor;
   } align_status_t;

   // One sequencer event per sampled tap
   typedef struct packed {
      logic valid;
      logic first;                                   // Clears the record on a new sweep
      tap_t tap;
   } sweep_evt_t;

endpackage

/* project.f */
common/bit_align_pkg.sv
verilog/lock_reset_sync.sv
training/tap_stepper.sv
training/eye_window_tracker.sv
training/training_sequencer.sv
verilog/bit_align_top.sv
verification/bit_align_properties.sv
verification/bit_align_tb.sv

/* training/eye_window_tracker.sv */
`timescale 1ns/1ns

module eye_window_tracker (
   input  logic                      sclk,
   input  logic                      train_reset,
   input  bit_align_pkg::sweep_evt_t sweep_evt,
   input  bit_align_pkg::iod_flags_t iod_flags,
   output bit_align_pkg::tap_t       win_left,
   output bit_align_pkg::tap_t       win_right,
   output bit_align_pkg::width_t     win_width
);
   import bit_align_pkg::*;

   logic   run_open;
   tap_t   run_start;
   tap_t   best_left;
   tap_t   best_right;
   width_t best_width;
   logic   clean;
   logic   open_now;
   logic   close_run;
   tap_t   close_start;
   tap_t   close_end;
   width_t close_width;
   width_t best_now;

   assign win_left  = best_left;
   assign win_right = best_right;
   assign win_width = best_width;

   // An out-of-range tap counts as a closed eye
   assign clean    = !(iod_flags.early || iod_flags.late || iod_flags.oor);
   assign open_now = sweep_evt.first ? 1'b0 : run_open;
   assign best_now = sweep_evt.first ? '0 : best_width;

   // --------------------
   // Run closing

   always_comb begin
      close_run   = 1'b0;
      close_start = run_start;
      close_end   = sweep_evt.tap;
      if (sweep_evt.valid) begin
         if (clean && sweep_evt.tap == tap_last) begin
            close_run   = 1'b1;                      // Last tap ends any open run
            close_start = open_now ? run_start : sweep_evt.tap;
         end else if (!clean && open_now) begin
            close_run = 1'b1;
            close_end = sweep_evt.tap - 1'b1;        // Previous tap was the last clean one
         end
      end
      close_width = {1'b0, close_end} - {1'b0, close_start} + 1'b1;
   end

   always_ff @(posedge sclk) begin
      if (train_reset) begin
         run_open   <= 1'b0;
         best_left  <= '0;
         best_right <= '0;
         best_width <= '0;
      end else begin
         if (sweep_evt.first) begin
            run_open   <= 1'b0;
            best_left  <= '0;
            best_right <= '0;
            best_width <= '0;
         end
         if (sweep_evt.valid) begin
            if (clean && !open_now) begin
               run_open  <= 1'b1;
               run_start <= sweep_evt.tap;
            end
            if (!clean) begin
               run_open <= 1'b0;
            end
            // Strictly wider only, so the first of equal eyes stays
            if (close_run && close_width > best_now) begin
               best_left  <= close_start;
               best_right <= close_end;
               best_width <= close_width;
            end
         end
      end
   end

endmodule

/* training/tap_stepper.sv */
`timescale 1ns/1ns

module tap_stepper #(
   parameter int wait_cnt_width = 3
) (
   input  logic sclk,
   input  logic reset,
   input  logic step_load,
   input  logic step_move,
   input  logic step_dir,
   output logic iod_ctrl_move,
   output logic iod_ctrl_load,
   output logic iod_ctrl_dir,
   output logic step_ready
);

   logic                      busy;
   logic [wait_cnt_width-1:0] wait_cnt;

   // Idle means ready for the next request
   assign step_ready = !busy;

   // --------------------
   // Pulse and settle

   always_ff @(posedge sclk) begin
      if (reset) begin
         busy          <= 1'b0;
         wait_cnt      <= '0;
         iod_ctrl_load <= 1'b0;
         iod_ctrl_move <= 1'b0;
         iod_ctrl_dir  <= 1'b0;
      end else begin
         iod_ctrl_load <= 1'b0;                      // Single-cycle pulses
         iod_ctrl_move <= 1'b0;
         if (!busy) begin
            if (step_load || step_move) begin
               busy          <= 1'b1;
               wait_cnt      <= '0;
               iod_ctrl_load <= step_load;
               iod_ctrl_move <= step_move && !step_load;   // Load wins
               iod_ctrl_dir  <= step_dir;
            end
         end else if (wait_cnt == '1) begin
            busy <= 1'b0;                            // Delay line has settled
         end else begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

endmodule

/* training/training_sequencer.sv */
`timescale 1ns/1ns

module training_sequencer #(
   parameter int min_window = 10
) (
   input  logic                         sclk,
   input  logic                         reset,
   input  logic                         train_reset,
   input  bit_align_pkg::iod_flags_t    iod_flags,
   input  bit_align_pkg::align_cmd_t    cmd,
   input  logic                         step_ready,
   input  bit_align_pkg::tap_t          win_left,
   input  bit_align_pkg::tap_t          win_right,
   input  bit_align_pkg::width_t        win_width,
   output logic                         step_load,
   output logic                         step_move,
   output logic                         step_dir,
   output logic                         clr_flags,
   output bit_align_pkg::sweep_evt_t    sweep_evt,
   output bit_align_pkg::align_status_t status,
   output bit_align_pkg::tap_t          tap_delay
);
   import bit_align_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_clear,
      st_load,
      st_sweep,
      st_evaluate,
      st_recentre,
      st_finished
   } state_t;

   state_t             state;
   align_status_t      status_q;
   logic               clr_q;
   logic               issued;                     // Request waiting for its settle
   logic               loaded;                     // Recentre load has completed
   logic               skip_run;
   tap_t               cur_tap;
   tap_t               centre;
   tap_t               move_cnt;
   logic               req_ok;
   logic               step_done;
   logic               sample_now;
   logic               run_start;
   tap_t               sample_tap;
   logic [tap_width:0] centre_sum;

   // --------------------
   // Step requests

   assign req_ok    = step_ready && !issued && !cmd.hold;
   assign step_done = step_ready && issued;        // Settle wait just ended

   assign step_load = req_ok && (state == st_load || (state == st_recentre && !loaded));
   assign step_move = req_ok && (state == st_sweep ||
                                 (state == st_recentre && loaded && move_cnt != centre));
   assign step_dir  = step_move;                   // Always stepping upwards

   // --------------------
   // Sweep sampling

   assign sample_now = step_done && (state == st_load || state == st_sweep);
   assign sample_tap = (state == st_sweep) ? cur_tap + 1'b1 : '0;
   assign sweep_evt  = '{valid: sample_now,
                         first: (state == st_clear) || (sample_now && state == st_load),
                         tap:   sample_tap};

   assign centre_sum = {1'b0, win_left} + {1'b0, win_right};
   assign run_start  = (state == st_idle) || cmd.restart;

   assign status    = status_q;
   assign clr_flags = clr_q;
   assign tap_delay = centre;

   always_ff @(posedge sclk) begin
      if (reset || train_reset) begin
         state    <= st_idle;
         status_q <= '0;
         clr_q    <= 1'b0;
         issued   <= 1'b0;
         loaded   <= 1'b0;
         skip_run <= 1'b0;
         cur_tap  <= '0;
         centre   <= '0;
         move_cnt <= '0;
      end else begin
         status_q.start <= 1'b0;
         clr_q          <= 1'b0;
         if (run_start) begin
            state    <= st_clear;
            status_q <= '{start: 1'b1, default: 1'b0};
            clr_q    <= 1'b1;
            issued   <= 1'b0;
            skip_run <= cmd.skip;
            centre   <= '0;
         end else begin
            if (step_load || step_move) begin
               issued <= 1'b1;
            end
            case (state)
               st_clear: begin
                  state <= skip_run ? st_evaluate : st_load;
               end
               st_load, st_sweep: begin
                  if (sample_now) begin
                     issued  <= 1'b0;
                     cur_tap <= sample_tap;
                     if (iod_flags.oor) begin
                        status_q.oor <= 1'b1;          // Sweep cut short
                        state        <= st_evaluate;
                     end else if (sample_tap == tap_last) begin
                        state <= st_evaluate;
                     end else begin
                        state <= st_sweep;
                     end
                  end
               end
               st_evaluate: begin
                  loaded   <= 1'b0;
                  move_cnt <= '0;
                  if (skip_run) begin
                     status_q.done <= 1'b1;
                     state         <= st_finished;
                  end else if (win_width < width_t'(min_window)) begin
                     status_q.err <= 1'b1;
                     state        <= st_finished;
                  end else begin
                     centre <= centre_sum[tap_width:1];
                     state  <= st_recentre;
                  end
               end
               st_recentre: begin
                  if (step_done) begin
                     issued <= 1'b0;
                     if (!loaded) begin
                        loaded <= 1'b1;
                     end else begin
                        move_cnt <= move_cnt + 1'b1;
                     end
                  end else if (!issued && loaded && move_cnt == centre) begin
                     status_q.done <= 1'b1;              // Delay sits at eye centre
                     state         <= st_finished;
                  end
               end
               default: begin
                  state <= st_finished;                // Wait for restart
               end
            endcase
         end
      end
   end

endmodule

/* verification/bit_align_properties.sv */
`timescale 1ns/1ns

module bit_align_properties #(
   parameter int wait_cnt_width = 3
) (
   input logic                         sclk,
   input logic                         reset,
   input bit_align_pkg::iod_ctrl_t     iod_ctrl,
   input bit_align_pkg::align_status_t status
);
   import bit_align_pkg::*;

   localparam int settle = 2 ** wait_cnt_width;

   logic pulse;
   int   fail_cnt = 0;                               // Assertion failures so far

   assign pulse = iod_ctrl.load || iod_ctrl.move;

   // --------------------
   // IOD pulse protocol

   move_single: assert property (
      @(posedge sclk) disable iff (reset)
      iod_ctrl.move |=> !iod_ctrl.move
   ) else begin
      $error("move pulse longer than one cycle");
      fail_cnt++;
   end

   load_move_apart: assert property (
      @(posedge sclk) disable iff (reset)
      !(iod_ctrl.load && iod_ctrl.move)
   ) else begin
      $error("load and move in the same cycle");
      fail_cnt++;
   end

   settle_gap: assert property (
      @(posedge sclk) disable iff (reset)
      pulse |=> !pulse [*settle]
   ) else begin
      $error("IOD pulses closer than the settle wait");
      fail_cnt++;
   end

   // --------------------
   // Status

   done_err_apart: assert property (
      @(posedge sclk) disable iff (reset)
      !(status.done && status.err)
   ) else begin
      $error("done and err high together");
      fail_cnt++;
   end

endmodule

/* verification/bit_align_tb.sv */
`timescale 1ns/1ns

module bit_align_tb;
   import bit_align_pkg::*;

   localparam int wait_width = 2;
   localparam int sweep_ns   = 256 * (2 ** wait_width + 2) * 4;
   localparam int run_limit  = 3 * 256 * (2 ** wait_width + 2);

   logic          sclk;
   logic          reset;
   logic          pll_lock;
   iod_flags_t    iod_flags;
   align_cmd_t    cmd;
   iod_ctrl_t     iod_ctrl;
   align_status_t status;
   tap_t          left_win;
   tap_t          right_win;
   tap_t          tap_delay;

   int model_tap;                                    // IOD delay line model
   int eye_l;
   int eye_r;
   int oor_limit;                                    // Negative when unused
   int loads_seen;
   int moves_seen;
   int exp_l;
   int exp_r;
   int held_tap;
   logic ld_q;
   logic mv_q;

   bit_align_top #(.rst_cnt_width(4), .wait_cnt_width(wait_width), .min_window(10)) i_dut (
      .sclk(sclk), .reset(reset), .pll_lock(pll_lock), .iod_flags(iod_flags), .cmd(cmd),
      .iod_ctrl(iod_ctrl), .status(status), .left_win(left_win), .right_win(right_win),
      .tap_delay(tap_delay)
   );

   bind bit_align_top bit_align_properties #(.wait_cnt_width(wait_cnt_width)) i_properties (
      .sclk(sclk), .reset(reset), .iod_ctrl(iod_ctrl), .status(status)
   );

   initial begin
      sclk = 1'b0;
      forever #2 sclk = ~sclk;
   end

   // --------------------
   // IOD model
   assign iod_flags = '{early: model_tap < eye_l, late: model_tap > eye_r,
                        oor: oor_limit >= 0 && model_tap > oor_limit};

   always @(posedge sclk) begin
      ld_q = iod_ctrl.load;
      mv_q = iod_ctrl.move && iod_ctrl.dir;
      #1;
      if (ld_q) begin
         model_tap  = 0;
         loads_seen = loads_seen + 1;
      end else if (mv_q) begin
         model_tap  = model_tap + 1;
         moves_seen = moves_seen + 1;
      end
   end

   // --------------------
   // Checks
   task automatic report_fatal(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display("Regression failed");
      $fatal(1, "stopped on first error");
   endtask

   task automatic expect_eq(input string name, input int got, input int exp);
      assert (got == exp) else begin
         $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
         $display("Regression failed");
         $fatal(1, "stopped on first error");
      end
   endtask

   task automatic tick(input int n);
      repeat (n) begin
         @(posedge sclk);
         #1;
         if (i_dut.i_properties.fail_cnt != 0) begin
            report_fatal("a protocol assertion on the IOD or status ports failed");
         end
      end
   endtask

   task automatic wait_result();
      int cycles;
      cycles = 0;
      while (!(status.done || status.err)) begin
         tick(1);
         cycles++;
         if (cycles > run_limit) report_fatal("neither done nor err rose within the run limit");
      end
   endtask

   task automatic start_run();
      cmd.restart = 1'b1;
      tick(1);
      cmd.restart = 1'b0;
      expect_eq("status.start", status.start, 1);
      expect_eq("iod_ctrl.clr_flags", iod_ctrl.clr_flags, 1);
   endtask

   task automatic check_centre(input int l, input int r);
      expect_eq("status.done", status.done, 1);
      expect_eq("status.err", status.err, 0);
      expect_eq("left_win", int'(left_win), l);
      expect_eq("right_win", int'(right_win), r);
      expect_eq("tap_delay", int'(tap_delay), (l + r) / 2);
      expect_eq("model tap", model_tap, int'(tap_delay));
   endtask

   task automatic pick_eye();
      eye_l = 20 + int'($urandom % 80);
      eye_r = eye_l + 9 + int'($urandom % 50);
   endtask

   // Watchdog
   initial begin
      #(8 * sweep_ns);
      $display("Timeout: the run did not finish in time");
      $display("Regression failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'h9794));
      reset = 1'b1;
      pll_lock = 1'b0;
      cmd = '0;
      model_tap = 0;
      oor_limit = -1;
      loads_seen = 0;
      moves_seen = 0;
      pick_eye();
      tick(2);
      reset = 1'b0;
      // Nothing may move while lock is low
      repeat (30) begin
         tick(1);
         expect_eq("status.start", status.start, 0);
         expect_eq("iod_ctrl", int'(iod_ctrl), 0);
      end
      pll_lock = 1'b1;
      repeat (17) begin                              // Sync plus hold-off
         tick(1);
         expect_eq("status.start", status.start, 0);
         expect_eq("iod_ctrl", int'(iod_ctrl), 0);
      end
      while (!status.start) tick(1);
      expect_eq("iod_ctrl.clr_flags", iod_ctrl.clr_flags, 1);
      wait_result();
      check_centre(eye_l, eye_r);
      expect_eq("status.oor", status.oor, 0);

      // Narrow eye
      eye_l = 60;
      eye_r = 65;
      start_run();
      wait_result();
      expect_eq("status.err", status.err, 1);
      expect_eq("status.done", status.done, 0);

      // Skip
      exp_l = loads_seen;
      exp_r = moves_seen;
      cmd.skip = 1'b1;
      start_run();
      tick(2);
      expect_eq("status.done", status.done, 1);
      cmd.skip = 1'b0;
      expect_eq("load pulses", loads_seen, exp_l);
      expect_eq("move pulses", moves_seen, exp_r);
      expect_eq("left_win", int'(left_win), 0);
      expect_eq("right_win", int'(right_win), 0);
      expect_eq("tap_delay", int'(tap_delay), 0);

      // Out of range inside the eye
      eye_l = 40;
      eye_r = 120;
      oor_limit = 100;
      start_run();
      wait_result();
      expect_eq("status.oor", status.oor, 1);
      check_centre(40, 100);
      oor_limit = -1;

      // Restart with a new eye and a hold during the sweep
      pick_eye();
      start_run();
      tick(100);
      cmd.hold = 1'b1;
      tick(2);
      held_tap = model_tap;
      tick(40);
      expect_eq("model tap on hold", model_tap, held_tap);
      cmd.hold = 1'b0;
      wait_result();
      check_centre(eye_l, eye_r);
      expect_eq("status.oor", status.oor, 0);

      // Lock loss
      pll_lock = 1'b0;
      tick(5);
      expect_eq("status.done", status.done, 0);
      if (i_dut.i_properties.fail_cnt == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         report_fatal("a protocol assertion failed during the run");
      end
   end

endmodule

/* verilog/bit_align_top.sv */
`timescale 1ns/1ns

module bit_align_top #(
   parameter int rst_cnt_width  = 10,
   parameter int wait_cnt_width = 3,
   parameter int min_window     = 10
) (
   input  logic                         sclk,
   input  logic                         reset,
   input  logic                         pll_lock,
   input  bit_align_pkg::iod_flags_t    iod_flags,
   input  bit_align_pkg::align_cmd_t    cmd,
   output bit_align_pkg::iod_ctrl_t     iod_ctrl,
   output bit_align_pkg::align_status_t status,
   output bit_align_pkg::tap_t          left_win,
   output bit_align_pkg::tap_t          right_win,
   output bit_align_pkg::tap_t          tap_delay
);
   import bit_align_pkg::*;

   logic       train_reset;
   logic       step_load;
   logic       step_move;
   logic       step_dir;
   logic       step_ready;
   logic       clr_flags;
   logic       ctrl_load;
   logic       ctrl_move;
   logic       ctrl_dir;
   sweep_evt_t sweep_evt;
   width_t     win_width;

   // Flag clear comes from the sequencer, the rest from the stepper
   assign iod_ctrl = '{clr_flags: clr_flags, load: ctrl_load, dir: ctrl_dir, move: ctrl_move};

   // --------------------
   // Lock gating

   lock_reset_sync #(
      .rst_cnt_width (rst_cnt_width)
   ) i_lock_reset_sync (
      .sclk        (sclk),
      .reset       (reset),
      .pll_lock    (pll_lock),
      .train_reset (train_reset)
   );

   // --------------------
   // Training

   training_sequencer #(
      .min_window (min_window)
   ) i_training_sequencer (
      .sclk        (sclk),
      .reset       (reset),
      .train_reset (train_reset),
      .iod_flags   (iod_flags),
      .cmd         (cmd),
      .step_ready  (step_ready),
      .win_left    (left_win),
      .win_right   (right_win),
      .win_width   (win_width),
      .step_load   (step_load),
      .step_move   (step_move),
      .step_dir    (step_dir),
      .clr_flags   (clr_flags),
      .sweep_evt   (sweep_evt),
      .status      (status),
      .tap_delay   (tap_delay)
   );

   tap_stepper #(
      .wait_cnt_width (wait_cnt_width)
   ) i_tap_stepper (
      .sclk          (sclk),
      .reset         (reset),
      .step_load     (step_load),
      .step_move     (step_move),
      .step_dir      (step_dir),
      .iod_ctrl_move (ctrl_move),
      .iod_ctrl_load (ctrl_load),
      .iod_ctrl_dir  (ctrl_dir),
      .step_ready    (step_ready)
   );

   eye_window_tracker i_eye_window_tracker (
      .sclk        (sclk),
      .train_reset (train_reset),
      .sweep_evt   (sweep_evt),
      .iod_flags   (iod_flags),
      .win_left    (left_win),
      .win_right   (right_win),
      .win_width   (win_width)
   );

endmodule

/* verilog/lock_reset_sync.sv */
`timescale 1ns/1ns

module lock_reset_sync #(
   parameter int rst_cnt_width = 10
) (
   input  logic sclk,
   input  logic reset,
   input  logic pll_lock,
   output logic train_reset
);

   logic                     lock_meta;
   logic                     lock_sync;
   logic [rst_cnt_width-1:0] hold_cnt;

   // Two-flop synchroniser for the asynchronous lock
   always_ff @(posedge sclk) begin
      if (reset) begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end else begin
         lock_meta <= pll_lock;
         lock_sync <= lock_meta;
      end
   end

   // Hold-off counter
   always_ff @(posedge sclk) begin
      if (reset) begin
         hold_cnt    <= '0;
         train_reset <= 1'b1;
      end else if (!lock_sync) begin
         hold_cnt    <= '0;                          // Any dropout restarts the wait
         train_reset <= 1'b1;
      end else if (train_reset) begin
         if (hold_cnt == '1) begin
            train_reset <= 1'b0;                     // Lock stable for 2**rst_cnt_width
         end else begin
            hold_cnt <= hold_cnt + 1'b1;
         end
      end
   end

endmodule
